// ==== src/decode_pkg.sv ====
/* RV32I only; the enum encodings below are shared with the later stages.
   INST_NOP is addi x0, x0, 0 and reads x0 only */
package decode_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_JALR,
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } alu_fun_t;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_X} op1_sel_t;

    typedef enum logic [2:0] {
        OP2_RS2, OP2_IMI, OP2_IMS, OP2_IMJ, OP2_IMU, OP2_X
    } op2_sel_t;

    typedef enum logic [3:0] {
        MEM_X, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_SB, MEM_SH, MEM_SW
    } mem_fun_t;

    typedef enum logic [2:0] {
        WB_X, WB_ALU, WB_PC, WB_MEMB, WB_MEMBU, WB_MEMH, WB_MEMHU, WB_MEMW
    } wb_sel_t;

    // major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // alu funct3, shared by reg and imm forms
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // srl / sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_LB   = 3'b000;
    localparam logic [2:0] F3_LH   = 3'b001;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_LBU  = 3'b100;
    localparam logic [2:0] F3_LHU  = 3'b101;
    localparam logic [2:0] F3_SB   = 3'b000;
    localparam logic [2:0] F3_SH   = 3'b001;
    localparam logic [2:0] F3_SW   = 3'b010;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra, srai

    localparam word_t INST_NOP = 32'h0000_0013;
    localparam word_t PC_NOP   = '0;

endpackage

// ==== src/decode_ctrl_if.sv ====
/* combinational decode results of the current instruction, no handshake */
interface decode_ctrl_if;
    import decode_pkg::*;

    alu_fun_t  alu_fun;
    op1_sel_t  op1_sel;
    op2_sel_t  op2_sel;
    mem_fun_t  mem_fun;
    logic      rf_wen;
    wb_sel_t   wb_sel;
    logic      jmp;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t wb_addr;

    modport producer (output alu_fun, op1_sel, op2_sel, mem_fun, rf_wen, wb_sel, jmp,
                      output rs1_addr, rs2_addr, wb_addr);
    modport consumer (input alu_fun, op1_sel, op2_sel, mem_fun, rf_wen, wb_sel, jmp,
                      input rs1_addr, rs2_addr, wb_addr);
    modport read (input rs1_addr, rs2_addr);
endinterface

// ==== src/inst_hold.sv ====
/* upstream must freeze in_inst while hazard_stall is high.
   a flush wins over the held instruction and presents a NOP */
module inst_hold (
    input  logic              clk,
    input  logic              reset,
    input  decode_pkg::word_t in_inst,
    input  decode_pkg::word_t in_pc,
    input  logic              mem_stall,
    input  logic              hazard_stall,
    input  logic              branch_flush,
    output decode_pkg::word_t inst,
    output decode_pkg::word_t pc
);
    import decode_pkg::*;

    word_t save_inst;
    word_t save_pc;
    logic  last_stall;  // previous cycle sent a bubble
    logic  stall;

    assign stall = mem_stall | hazard_stall;

    always_comb begin
        if (branch_flush) begin
            inst = INST_NOP;
            pc   = PC_NOP;
        end else if (last_stall) begin
            inst = save_inst;
            pc   = save_pc;
        end else begin
            inst = in_inst;
            pc   = in_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_stall <= 1'b0;
        end else begin
            last_stall <= stall;
        end
    end

    always_ff @(posedge clk) begin
        if (stall) begin
            save_inst <= inst;  // a flushed NOP is held too
            save_pc   <= pc;
        end
    end
endmodule

// ==== src/hazard_detect.sv ====
/* rs2 is compared for every format, so I-type words may stall needlessly */
module hazard_detect (
    decode_ctrl_if.read           ctrl,
    input  logic                  exe_rf_wen,
    input  decode_pkg::reg_addr_t exe_wb_addr,
    input  logic                  mem_rf_wen,
    input  decode_pkg::reg_addr_t mem_wb_addr,
    input  logic                  wb_rf_wen,
    input  decode_pkg::reg_addr_t wb_wb_addr,
    output logic                  hazard_stall
);
    logic exe_hit;
    logic mem_hit;
    logic wb_hit;

    // x0 writes never conflict
    assign exe_hit = exe_rf_wen && (exe_wb_addr != '0)
                     && (exe_wb_addr == ctrl.rs1_addr || exe_wb_addr == ctrl.rs2_addr);
    assign mem_hit = mem_rf_wen && (mem_wb_addr != '0)
                     && (mem_wb_addr == ctrl.rs1_addr || mem_wb_addr == ctrl.rs2_addr);
    assign wb_hit  = wb_rf_wen && (wb_wb_addr != '0)
                     && (wb_wb_addr == ctrl.rs1_addr || wb_wb_addr == ctrl.rs2_addr);

    assign hazard_stall = exe_hit | mem_hit | wb_hit;
endmodule

// ==== src/inst_decoder.sv ====
/* RV32I base set only; anything outside the table decodes as an add
   with no register, memory or write-back effect */
module inst_decoder (
    input  decode_pkg::word_t inst,
    decode_ctrl_if.producer   ctrl
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       load_ok;
    logic       store_ok;
    logic       branch_ok;
    logic       op_ok;
    logic       imm_ok;

    function automatic alu_fun_t alu_op(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            F3_ADD:  alu_op = sub_sra ? ALU_SUB : ALU_ADD;
            F3_SLL:  alu_op = ALU_SLL;
            F3_SLT:  alu_op = ALU_SLT;
            F3_SLTU: alu_op = ALU_SLTU;
            F3_XOR:  alu_op = ALU_XOR;
            F3_SR:   alu_op = sub_sra ? ALU_SRA : ALU_SRL;
            F3_OR:   alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign alt    = (funct7 == F7_ALT);

    assign load_ok   = funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
    assign store_ok  = funct3 inside {F3_SB, F3_SH, F3_SW};
    assign branch_ok = funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    assign op_ok     = (funct7 == F7_BASE) || (alt && funct3 inside {F3_ADD, F3_SR});
    // shift immediates carry funct7 in the upper imm bits
    assign imm_ok    = (funct3 == F3_SR)  ? (funct7 == F7_BASE || alt) :
                       (funct3 == F3_SLL) ? (funct7 == F7_BASE) : 1'b1;

    assign ctrl.rs1_addr = inst[19:15];
    assign ctrl.rs2_addr = inst[24:20];
    assign ctrl.wb_addr  = inst[11:7];

    always_comb begin
        ctrl.alu_fun = ALU_ADD;
        ctrl.op1_sel = OP1_X;
        ctrl.op2_sel = OP2_X;
        ctrl.mem_fun = MEM_X;
        ctrl.rf_wen  = 1'b0;
        ctrl.wb_sel  = WB_X;
        ctrl.jmp     = 1'b0;
        case (opcode)
            OPC_LOAD: if (load_ok) begin
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_IMI;
                ctrl.rf_wen  = 1'b1;
                case (funct3)
                    F3_LB:   ctrl.mem_fun = MEM_LB;
                    F3_LH:   ctrl.mem_fun = MEM_LH;
                    F3_LW:   ctrl.mem_fun = MEM_LW;
                    F3_LBU:  ctrl.mem_fun = MEM_LBU;
                    default: ctrl.mem_fun = MEM_LHU;
                endcase
                case (funct3)
                    F3_LB:   ctrl.wb_sel = WB_MEMB;
                    F3_LH:   ctrl.wb_sel = WB_MEMH;
                    F3_LW:   ctrl.wb_sel = WB_MEMW;
                    F3_LBU:  ctrl.wb_sel = WB_MEMBU;
                    default: ctrl.wb_sel = WB_MEMHU;
                endcase
            end
            OPC_STORE: if (store_ok) begin
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_IMS;  // address = rs1 + imm_s
                case (funct3)
                    F3_SB:   ctrl.mem_fun = MEM_SB;
                    F3_SH:   ctrl.mem_fun = MEM_SH;
                    default: ctrl.mem_fun = MEM_SW;
                endcase
            end
            OPC_OP: if (op_ok) begin
                ctrl.alu_fun = alu_op(funct3, alt);
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_RS2;
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_sel  = WB_ALU;
            end
            OPC_OP_IMM: if (imm_ok) begin
                ctrl.alu_fun = alu_op(funct3, funct3 == F3_SR && alt);
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_IMI;
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_sel  = WB_ALU;
            end
            OPC_BRANCH: if (branch_ok) begin
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_RS2;
                case (funct3)
                    F3_BEQ:  ctrl.alu_fun = BR_BEQ;
                    F3_BNE:  ctrl.alu_fun = BR_BNE;
                    F3_BLT:  ctrl.alu_fun = BR_BLT;
                    F3_BGE:  ctrl.alu_fun = BR_BGE;
                    F3_BLTU: ctrl.alu_fun = BR_BLTU;
                    default: ctrl.alu_fun = BR_BGEU;
                endcase
            end
            OPC_JAL: begin
                ctrl.op1_sel = OP1_PC;
                ctrl.op2_sel = OP2_IMJ;
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_sel  = WB_PC;  // link = pc + 4 downstream
                ctrl.jmp     = 1'b1;
            end
            OPC_JALR: if (funct3 == F3_JALR) begin
                ctrl.alu_fun = ALU_JALR;
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_IMI;
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_sel  = WB_PC;
                ctrl.jmp     = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                ctrl.op1_sel = (opcode == OPC_AUIPC) ? OP1_PC : OP1_X;
                ctrl.op2_sel = OP2_IMU;
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_sel  = WB_ALU;
            end
            default: ;
        endcase
    end
endmodule

// ==== src/id_ex_register.sv ====
/* rs1_data and rs2_data must be valid in the same cycle as inst.
   stall or reset loads a bubble, NOP with all data zero */
module id_ex_register (
    input  logic                  clk,
    input  logic                  reset,
    input  decode_pkg::word_t     inst,
    input  decode_pkg::word_t     pc,
    decode_ctrl_if.consumer       ctrl,
    input  decode_pkg::word_t     rs1_data,
    input  decode_pkg::word_t     rs2_data,
    input  logic                  mem_stall,
    input  logic                  hazard_stall,
    output decode_pkg::word_t     out_inst,
    output decode_pkg::word_t     out_pc,
    output decode_pkg::word_t     op1_data,
    output decode_pkg::word_t     op2_data,
    output decode_pkg::word_t     store_data,
    output decode_pkg::word_t     imm_b,
    output decode_pkg::alu_fun_t  alu_fun,
    output decode_pkg::mem_fun_t  mem_fun,
    output logic                  rf_wen,
    output decode_pkg::wb_sel_t   wb_sel,
    output decode_pkg::reg_addr_t wb_addr,
    output logic                  jmp_flg
);
    import decode_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b_sext;
    word_t imm_j;
    word_t imm_u;
    word_t rs1_val;
    word_t rs2_val;
    word_t op1_next;
    word_t op2_next;
    logic  stall;

    assign stall = mem_stall | hazard_stall;

    assign imm_i      = {{20{inst[31]}}, inst[31:20]};
    assign imm_s      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b_sext = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j      = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u      = {inst[31:12], 12'b0};

    // x0 reads as zero whatever the port returns
    assign rs1_val = (ctrl.rs1_addr == '0) ? '0 : rs1_data;
    assign rs2_val = (ctrl.rs2_addr == '0) ? '0 : rs2_data;

    always_comb begin
        case (ctrl.op1_sel)
            OP1_RS1: op1_next = rs1_val;
            OP1_PC:  op1_next = pc;
            default: op1_next = '0;
        endcase
        case (ctrl.op2_sel)
            OP2_RS2: op2_next = rs2_val;
            OP2_IMI: op2_next = imm_i;
            OP2_IMS: op2_next = imm_s;
            OP2_IMJ: op2_next = imm_j;
            OP2_IMU: op2_next = imm_u;
            default: op2_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || stall) begin
            out_inst   <= INST_NOP;
            out_pc     <= PC_NOP;
            op1_data   <= '0;
            op2_data   <= '0;
            store_data <= '0;
            imm_b      <= '0;
            alu_fun    <= ALU_ADD;
            mem_fun    <= MEM_X;
            rf_wen     <= 1'b0;
            wb_sel     <= WB_X;
            wb_addr    <= '0;
            jmp_flg    <= 1'b0;
        end else begin
            out_inst   <= inst;
            out_pc     <= pc;
            op1_data   <= op1_next;
            op2_data   <= op2_next;
            store_data <= rs2_val;
            imm_b      <= imm_b_sext;  // branch target is computed in execute
            alu_fun    <= ctrl.alu_fun;
            mem_fun    <= ctrl.mem_fun;
            rf_wen     <= ctrl.rf_wen;
            wb_sel     <= ctrl.wb_sel;
            wb_addr    <= ctrl.wb_addr;
            jmp_flg    <= ctrl.jmp;
        end
    end
endmodule

// ==== src/decode_stage.sv ====
/* register file is outside; rs1/rs2_addr must be answered combinationally.
   upstream freezes while hazard_stall is high */
module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  decode_pkg::word_t     in_inst,
    input  decode_pkg::word_t     in_pc,
    input  decode_pkg::word_t     rs1_data,
    input  decode_pkg::word_t     rs2_data,
    input  logic                  mem_stall,
    input  logic                  branch_flush,
    input  logic                  exe_rf_wen,
    input  decode_pkg::reg_addr_t exe_wb_addr,
    input  logic                  mem_rf_wen,
    input  decode_pkg::reg_addr_t mem_wb_addr,
    input  logic                  wb_rf_wen,
    input  decode_pkg::reg_addr_t wb_wb_addr,
    output decode_pkg::reg_addr_t rs1_addr,
    output decode_pkg::reg_addr_t rs2_addr,
    output logic                  hazard_stall,
    output decode_pkg::word_t     out_inst,
    output decode_pkg::word_t     out_pc,
    output decode_pkg::word_t     op1_data,
    output decode_pkg::word_t     op2_data,
    output decode_pkg::word_t     store_data,
    output decode_pkg::word_t     imm_b,
    output decode_pkg::alu_fun_t  alu_fun,
    output decode_pkg::mem_fun_t  mem_fun,
    output logic                  rf_wen,
    output decode_pkg::wb_sel_t   wb_sel,
    output decode_pkg::reg_addr_t wb_addr,
    output logic                  jmp_flg
);
    import decode_pkg::*;

    word_t inst;  // after hold / flush select
    word_t pc;

    decode_ctrl_if ctrl ();

    assign rs1_addr = ctrl.rs1_addr;
    assign rs2_addr = ctrl.rs2_addr;

    inst_hold u_inst_hold (
        .clk          (clk),
        .reset        (reset),
        .in_inst      (in_inst),
        .in_pc        (in_pc),
        .mem_stall    (mem_stall),
        .hazard_stall (hazard_stall),
        .branch_flush (branch_flush),
        .inst         (inst),
        .pc           (pc)
    );

    inst_decoder u_inst_decoder (
        .inst (inst),
        .ctrl (ctrl)
    );

    hazard_detect u_hazard_detect (
        .ctrl         (ctrl),
        .exe_rf_wen   (exe_rf_wen),
        .exe_wb_addr  (exe_wb_addr),
        .mem_rf_wen   (mem_rf_wen),
        .mem_wb_addr  (mem_wb_addr),
        .wb_rf_wen    (wb_rf_wen),
        .wb_wb_addr   (wb_wb_addr),
        .hazard_stall (hazard_stall)
    );

    id_ex_register u_id_ex_register (
        .clk          (clk),
        .reset        (reset),
        .inst         (inst),
        .pc           (pc),
        .ctrl         (ctrl),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .mem_stall    (mem_stall),
        .hazard_stall (hazard_stall),
        .out_inst     (out_inst),
        .out_pc       (out_pc),
        .op1_data     (op1_data),
        .op2_data     (op2_data),
        .store_data   (store_data),
        .imm_b        (imm_b),
        .alu_fun      (alu_fun),
        .mem_fun      (mem_fun),
        .rf_wen       (rf_wen),
        .wb_sel       (wb_sel),
        .wb_addr      (wb_addr),
        .jmp_flg      (jmp_flg)
    );
endmodule

// ==== test/decode_stage_assertions.sv ====
/* bound into id_ex_register; stall and reset must both leave a bubble behind */
module decode_stage_assertions (
    input logic                 clk,
    input logic                 reset,
    input logic                 mem_stall,
    input logic                 hazard_stall,
    input decode_pkg::word_t    out_inst,
    input decode_pkg::word_t    out_pc,
    input decode_pkg::mem_fun_t mem_fun,
    input logic                 rf_wen,
    input decode_pkg::wb_sel_t  wb_sel,
    input logic                 jmp_flg
);
    timeunit 1ns;
    timeprecision 100ps;
    import decode_pkg::*;

    // any stall turns the next output into a NOP with no side effects
    stall_bubble: assert property (@(posedge clk) disable iff (reset)
        (mem_stall || hazard_stall) |=>
            (out_inst == INST_NOP && !rf_wen && !jmp_flg && mem_fun == MEM_X))
        else $error("stall was not followed by a bubble");

    reset_idle: assert property (@(posedge clk)
        reset |=> (out_inst == INST_NOP && out_pc == PC_NOP && !rf_wen && !jmp_flg
                   && mem_fun == MEM_X && wb_sel == WB_X))
        else $error("outputs not inactive after reset");
endmodule

bind id_ex_register decode_stage_assertions u_decode_assertions (
    .clk          (clk),
    .reset        (reset),
    .mem_stall    (mem_stall),
    .hazard_stall (hazard_stall),
    .out_inst     (out_inst),
    .out_pc       (out_pc),
    .mem_fun      (mem_fun),
    .rf_wen       (rf_wen),
    .wb_sel       (wb_sel),
    .jmp_flg      (jmp_flg)
);

// ==== test/decode_stage_tb.sv ====
/* run from the project root so test/decode_testdata.txt is found.
   register file model: xn reads n * 0x10003 */
module decode_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import decode_pkg::*;

    localparam int NUM_VEC          = 17;
    localparam int NUM_FIELDS       = 10;
    localparam int RESET_CYCLES     = 16;
    localparam int MEM_STALL_CYCLES = 4;
    // about twice what reset plus the five tests need
    localparam int CYCLE_LIMIT = 2 * (RESET_CYCLES + NUM_VEC * 4 + MEM_STALL_CYCLES + 12);

    logic      clk;
    logic      reset;
    word_t     in_inst;
    word_t     in_pc;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      mem_stall;
    logic      branch_flush;
    logic      exe_rf_wen;
    reg_addr_t exe_wb_addr;
    logic      mem_rf_wen;
    reg_addr_t mem_wb_addr;
    logic      wb_rf_wen;
    reg_addr_t wb_wb_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      hazard_stall;
    word_t     out_inst;
    word_t     out_pc;
    word_t     op1_data;
    word_t     op2_data;
    word_t     store_data;
    word_t     imm_b;
    alu_fun_t  alu_fun;
    mem_fun_t  mem_fun;
    logic      rf_wen;
    wb_sel_t   wb_sel;
    reg_addr_t wb_addr;
    logic      jmp_flg;

    logic [31:0] vec_mem [0:NUM_VEC*NUM_FIELDS-1];
    logic [31:0] rand_state = 32'h595c_a174;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;

    decode_stage dut (.*);

    function automatic word_t reg_value(input reg_addr_t n);
        return 32'h10003 * n;  // x0 gives zero
    endfunction

    // B-type offset, bit 0 always zero
    function automatic word_t branch_offset(input logic [31:0] inst);
        logic [12:0] off;
        off = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        return {{19{off[12]}}, off};
    endfunction

    assign rs1_data = reg_value(rs1_addr);
    assign rs2_data = reg_value(rs2_addr);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: %0d cycles passed and the tests did not finish", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // stage writes a nonzero register that the instruction reads
    function automatic logic dest_hits(input logic wen, input reg_addr_t dest,
                                       input logic [31:0] inst);
        return wen && dest != 5'd0 && (dest == inst[19:15] || dest == inst[24:20]);
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_decode(input string tag, input logic [31:0] e_inst,
                                input logic [31:0] e_pc, input logic [31:0] e_alu,
                                input logic [31:0] e_op1, input logic [31:0] e_op2,
                                input logic [31:0] e_mem, input logic [31:0] e_rf,
                                input logic [31:0] e_wb, input logic [31:0] e_wba,
                                input logic [31:0] e_jmp);
        compare({tag, " out_inst"}, out_inst, e_inst);
        compare({tag, " out_pc"}, out_pc, e_pc);
        compare({tag, " alu_fun"}, alu_fun, e_alu);
        compare({tag, " op1_data"}, op1_data, e_op1);
        compare({tag, " op2_data"}, op2_data, e_op2);
        compare({tag, " mem_fun"}, mem_fun, e_mem);
        compare({tag, " rf_wen"}, rf_wen, e_rf);
        compare({tag, " wb_sel"}, wb_sel, e_wb);
        compare({tag, " wb_addr"}, wb_addr, e_wba);
        compare({tag, " jmp_flg"}, jmp_flg, e_jmp);
    endtask

    task automatic check_vector(input int idx);
        int    b;
        string tag;
        b = idx * NUM_FIELDS;
        tag = $sformatf("vector %0d", idx);
        check_decode(tag, vec_mem[b], vec_mem[b+1], vec_mem[b+2],
                     vec_mem[b+3], vec_mem[b+4], vec_mem[b+5], vec_mem[b+6],
                     vec_mem[b+7], vec_mem[b+8], vec_mem[b+9]);
        // rs2 read goes out for every format
        compare({tag, " store_data"}, store_data, reg_value(vec_mem[b][24:20]));
        compare({tag, " imm_b"}, imm_b, branch_offset(vec_mem[b]));
    endtask

    task automatic check_bubble(input string tag);
        check_decode(tag, 32'h0000_0013, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        compare({tag, " store_data"}, store_data, 0);
        compare({tag, " imm_b"}, imm_b, 0);
    endtask

    task automatic present(input int idx);
        in_inst = vec_mem[idx*NUM_FIELDS];
        in_pc   = vec_mem[idx*NUM_FIELDS+1];
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic pick_dest(input logic [31:0] inst, output logic wen, output reg_addr_t dest);
        rand_state = lcg_step(rand_state);
        wen = rand_state[31];
        case (rand_state[29:28])  // lean toward real source registers
            2'd0:    dest = inst[19:15];
            2'd1:    dest = inst[24:20];
            default: dest = rand_state[20:16];
        endcase
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
    endtask

    initial begin
        int  err_start;
        int  stall_rounds;
        logic exp_stall;
        reset        = 1'b1;
        in_inst      = 32'h0000_0013;
        in_pc        = '0;
        mem_stall    = 1'b0;
        branch_flush = 1'b0;
        exe_rf_wen   = 1'b0;
        exe_wb_addr  = '0;
        mem_rf_wen   = 1'b0;
        mem_wb_addr  = '0;
        wb_rf_wen    = 1'b0;
        wb_wb_addr   = '0;
        $readmemh("test/decode_testdata.txt", vec_mem);
        if ($isunknown(vec_mem[0]) || $isunknown(vec_mem[NUM_VEC*NUM_FIELDS-1])) begin
            errors++;
            $display("Test data file is missing or shorter than %0d vectors", NUM_VEC);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;

        err_start = errors;
        check_bubble("reset");
        finish_test("outputs after reset", err_start);

        err_start = errors;
        for (int i = 0; i < NUM_VEC; i++) begin
            present(i);
            next_cycle();
            check_vector(i);
        end
        finish_test("back to back decode", err_start);

        err_start = errors;
        stall_rounds = 0;
        for (int i = 0; i < NUM_VEC; i++) begin
            present(i);
            pick_dest(in_inst, exe_rf_wen, exe_wb_addr);
            pick_dest(in_inst, mem_rf_wen, mem_wb_addr);
            pick_dest(in_inst, wb_rf_wen, wb_wb_addr);
            #10;
            exp_stall = dest_hits(exe_rf_wen, exe_wb_addr, in_inst)
                        || dest_hits(mem_rf_wen, mem_wb_addr, in_inst)
                        || dest_hits(wb_rf_wen, wb_wb_addr, in_inst);
            compare($sformatf("vector %0d rs1_addr", i), rs1_addr, in_inst[19:15]);
            compare($sformatf("vector %0d rs2_addr", i), rs2_addr, in_inst[24:20]);
            compare($sformatf("vector %0d hazard_stall", i), hazard_stall, exp_stall);
            next_cycle();
            if (exp_stall) begin
                stall_rounds++;
                check_bubble($sformatf("hazard bubble %0d", i));
                exe_rf_wen = 1'b0;
                mem_rf_wen = 1'b0;
                wb_rf_wen  = 1'b0;
                next_cycle();
            end
            check_vector(i);
        end
        exe_rf_wen = 1'b0;
        mem_rf_wen = 1'b0;
        wb_rf_wen  = 1'b0;
        if (stall_rounds == 0 || stall_rounds == NUM_VEC) begin
            errors++;
            $display("Hazard test saw only one outcome in %0d rounds", NUM_VEC);
        end
        finish_test("random hazards", err_start);

        err_start = errors;
        present(6);
        mem_stall = 1'b1;
        for (int c = 0; c < MEM_STALL_CYCLES; c++) begin
            next_cycle();
            check_bubble($sformatf("mem stall cycle %0d", c));
            if (c == 0) begin
                present(7);  // held copy must still come out first
            end
        end
        mem_stall = 1'b0;
        next_cycle();
        check_vector(6);
        next_cycle();
        check_vector(7);
        finish_test("memory stall", err_start);

        err_start = errors;
        present(0);
        mem_stall = 1'b1;
        next_cycle();
        check_bubble("flush setup");
        mem_stall    = 1'b0;
        branch_flush = 1'b1;
        next_cycle();
        // addi x0, x0, 0 decoded normally
        check_decode("flush", 32'h0000_0013, 0, 0, 0, 0, 0, 1, 1, 0, 0);
        branch_flush = 1'b0;
        present(1);
        next_cycle();
        check_vector(1);
        finish_test("flush of held instruction", err_start);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end
endmodule

// ==== compile.f ====
src/decode_pkg.sv
src/decode_ctrl_if.sv
src/inst_hold.sv
src/hazard_detect.sv
src/inst_decoder.sv
src/id_ex_register.sv
src/decode_stage.sv
test/decode_stage_assertions.sv
test/decode_stage_tb.sv

// ==== test/decode_testdata.txt ====
// inst     pc       alu  op1      op2      mem rf_wen wb_sel wb_addr jmp
// all hex; enum columns use the package encodings, xn holds n * 10003
002081b3 00000100 00 00010003 00020006 0 1 1 03 0 // add x3, x1, x2
40628233 00000104 01 0005000f 00060012 0 1 1 04 0 // sub x4, x5, x6
409453b3 00000108 07 00080018 0009001b 0 1 1 07 0 // sra x7, x8, x9
fff00513 0000010c 00 00000000 ffffffff 0 1 1 0a 0 // addi x10, x0, -1
40365593 00000110 07 000c0024 00000403 0 1 1 0b 0 // srai x11, x12, 3
7ff73693 00000114 09 000e002a 000007ff 0 1 1 0d 0 // sltiu x13, x14, 2047
ffc12783 00000118 00 00020006 fffffffc 5 1 7 0f 0 // lw x15, -4(x2)
0081c803 0000011c 00 00030009 00000008 2 1 4 10 0 // lbu x16, 8(x3)
00532a23 00000120 00 00060012 00000014 8 0 0 14 0 // sw x5, 20(x6)
fe709f23 00000124 00 00010003 fffffffe 7 0 0 1e 0 // sh x7, -2(x1)
00208863 00000128 0b 00010003 00020006 0 0 0 10 0 // beq x1, x2, +16
fea4fce3 0000012c 10 0009001b 000a001e 0 0 0 19 0 // bgeu x9, x10, -8
001000ef 00000130 00 00000130 00000800 0 1 2 01 1 // jal x1, +2048
00c302e7 00000134 0a 00060012 0000000c 0 1 2 05 1 // jalr x5, 12(x6)
abcdea37 00000138 00 00000000 abcde000 0 1 1 14 0 // lui x20, 0xabcde
80000a97 0000013c 00 0000013c 80000000 0 1 1 15 0 // auipc x21, 0x80000
ffffffff 00000140 00 00000000 00000000 0 0 0 1f 0 // not in the table
